// ==== divsqrt_settings.svh ====
`ifndef DIVSQRT_SETTINGS_SVH
`define DIVSQRT_SETTINGS_SVH

// ----------------------------------------
// Pipeline depths
// ----------------------------------------
// Register stages in front of the control FSM
`define DIVSQRT_IN_REGS 1
// Register stages behind the result select
`define DIVSQRT_OUT_REGS 1

// ----------------------------------------
// Number format
// ----------------------------------------
`define FP16_WIDTH 16
// Stored fraction bits, hidden one not counted
`define FP16_MANT_BITS 10
`define FP16_BIAS 15

// Iteration cycles, 11 significand bits and 2 guard positions
`define DIVSQRT_ITER 13

`endif

// ==== fp16_pkg.sv ====
`include "divsqrt_settings.svh"

package fp16_pkg;

  // Exponent field width follows from the word and fraction sizes
  localparam int unsigned EXP_BITS = `FP16_WIDTH - `FP16_MANT_BITS - 1;

  // ----------------------------------------
  // Word layout
  // ----------------------------------------
  typedef struct packed {
    logic                       sign;
    logic [EXP_BITS-1:0]        exponent;
    logic [`FP16_MANT_BITS-1:0] fraction;
  } fp16_fields_t;

  // Pipelines move raw bits, the core reads fields
  typedef union packed {
    logic [`FP16_WIDTH-1:0] raw;
    fp16_fields_t           f;
  } fp16_u;

  // ----------------------------------------
  // Exception flags
  // ----------------------------------------
  typedef struct packed {
    // Invalid operation
    logic nv;
    // Divide by zero
    logic dz;
    // Overflow
    logic of;
    // Underflow
    logic uf;
    // Inexact
    logic nx;
  } status_t;

  // Canonical quiet NaN
  localparam logic [`FP16_WIDTH-1:0] FP16_QNAN = 16'h7E00;
  // Largest finite magnitude, positive sign
  localparam logic [`FP16_WIDTH-1:0] FP16_MAX_FINITE = 16'h7BFF;

endpackage

// ==== divsqrt_op_pkg.sv ====
package divsqrt_op_pkg;

  import fp16_pkg::*;

  // Operation select
  typedef enum logic {
    DIV  = 1'b0,
    SQRT = 1'b1
  } divsqrt_op_e;

  // Request carried by the input pipeline, b unused for SQRT
  typedef struct packed {
    divsqrt_op_e op;
    fp16_u       a;
    fp16_u       b;
  } divsqrt_req_t;

  // Response carried by the output pipeline
  typedef struct packed {
    fp16_u   result;
    status_t status;
  } divsqrt_rsp_t;

  // Control FSM
  typedef enum logic [1:0] {IDLE, BUSY, HOLD} ctrl_state_e;

endpackage

// ==== divsqrt_if.sv ====
`timescale 1ns/1ps

interface divsqrt_if
  import fp16_pkg::*;
();

  // Control to core, starts are single-cycle pulses
  logic    start_div;
  logic    start_sqrt;
  fp16_u   operand_a;
  fp16_u   operand_b;
  // Abort, core back to ready next cycle
  logic    kill;

  // Core to control
  logic    unit_ready;
  // One-cycle pulse, result and status valid with it
  logic    unit_done;
  fp16_u   result;
  status_t status;

  modport ctrl (
    output start_div, start_sqrt, operand_a, operand_b, kill,
    input  unit_ready, unit_done, result, status
  );

  modport core (
    input  start_div, start_sqrt, operand_a, operand_b, kill,
    output unit_ready, unit_done, result, status
  );

endinterface

// ==== pipe_stages.sv ====
`timescale 1ns/1ps

module pipe_stages #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 1
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             flush_i,
  // Upstream side
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  // Downstream side
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o,
  // Some stage holds an item
  output logic             any_valid_o
);

  // Index i is the signal after i stages, index 0 is the input
  logic             valid_s [0:DEPTH];
  logic             ready_s [0:DEPTH];
  logic [WIDTH-1:0] data_s  [0:DEPTH];
  // Running OR of stage valids
  logic             occ_s   [0:DEPTH];

  assign valid_s[0] = valid_i;
  assign data_s[0]  = data_i;
  assign occ_s[0]   = 1'b0;
  assign ready_o    = ready_s[0];

  for (genvar i = 0; i < DEPTH; i++) begin : gen_stage
    // Advance when the next stage moves on or only holds a bubble
    assign ready_s[i] = ready_s[i+1] | ~valid_s[i+1];

    // Valid bit, cleared by reset and flush
    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_s[i+1] <= 1'b0;
      end else if (ready_s[i]) begin
        valid_s[i+1] <= valid_s[i];
      end
    end

    // Payload loads only when a real item moves in
    always_ff @(posedge clk_i) begin
      if (ready_s[i] && valid_s[i]) begin
        data_s[i+1] <= data_s[i];
      end
    end

    assign occ_s[i+1] = occ_s[i] | valid_s[i+1];
  end

  // Ready enters from the downstream end
  assign ready_s[DEPTH] = ready_i;
  assign valid_o        = valid_s[DEPTH];
  assign data_o         = data_s[DEPTH];
  assign any_valid_o    = occ_s[DEPTH];

endmodule

// ==== divsqrt_ctrl.sv ====
`timescale 1ns/1ps

module divsqrt_ctrl
  import fp16_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_i,
  input  logic           flush_i,
  // Head of the input pipeline
  input  logic           req_valid_i,
  output logic           req_ready_o,
  input  divsqrt_req_t   req_i,
  // Into the output pipeline
  output logic           rsp_valid_o,
  input  logic           rsp_ready_i,
  output divsqrt_rsp_t   rsp_o,
  // Operation in the core or result waiting
  output logic           busy_o,
  divsqrt_if.ctrl        unit
);

  ctrl_state_e state_q, state_d;
  logic        req_ready;
  logic        rsp_valid;
  logic        busy;
  logic        hold_en;
  logic        can_issue;
  logic        op_start;
  fp16_u       held_result_q;
  status_t     held_status_q;

  // ----------------------------------------
  // Start of an operation
  // ----------------------------------------
  // Request present and the core will take it this cycle
  assign can_issue = req_valid_i & unit.unit_ready;
  // Accepting the head is the start
  assign op_start  = req_valid_i & req_ready;

  assign unit.start_div  = op_start & (req_i.op == DIV);
  assign unit.start_sqrt = op_start & (req_i.op == SQRT);
  assign unit.operand_a  = req_i.a;
  assign unit.operand_b  = req_i.b;
  assign unit.kill       = flush_i;

  // ----------------------------------------
  // Control FSM
  // ----------------------------------------
  always_comb begin
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    busy      = 1'b0;
    hold_en   = 1'b0;
    state_d   = state_q;

    unique case (state_q)
      IDLE: begin
        req_ready = unit.unit_ready;
        if (can_issue) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        busy = 1'b1;
        if (unit.unit_done) begin
          rsp_valid = 1'b1;
          if (rsp_ready_i) begin
            // Result taken so the next one may start right away
            req_ready = unit.unit_ready;
            state_d   = can_issue ? BUSY : IDLE;
          end else begin
            // Park the result until downstream frees up
            hold_en = 1'b1;
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        busy      = 1'b1;
        rsp_valid = 1'b1;
        if (rsp_ready_i) begin
          req_ready = unit.unit_ready;
          state_d   = can_issue ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      req_ready = 1'b0;
      rsp_valid = 1'b0;
      busy      = 1'b0;
      hold_en   = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------
  // Hold register and output select
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      held_result_q <= unit.result;
      held_status_q <= unit.status;
    end
  end

  // Core outputs are stale once in HOLD
  always_comb begin
    if (state_q == HOLD) begin
      rsp_o.result = held_result_q;
      rsp_o.status = held_status_q;
    end else begin
      rsp_o.result = unit.result;
      rsp_o.status = unit.status;
    end
  end

  assign req_ready_o = req_ready;
  assign rsp_valid_o = rsp_valid;
  assign busy_o      = busy;

endmodule

// ==== fp16_divsqrt_iter.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module fp16_divsqrt_iter
  import fp16_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_i,
  divsqrt_if.core unit
);

  // Quotient and root bits, one per iteration
  localparam int unsigned QW = `DIVSQRT_ITER;
  // Significand with hidden one
  localparam int unsigned MW = `FP16_MANT_BITS + 1;
  // Partial remainder, wide enough for the sqrt trial term
  localparam int unsigned RW = QW + 3;
  // Sqrt radicand, two bits consumed per iteration
  localparam int unsigned SW = 2 * QW;
  localparam int unsigned CW = $clog2(QW);
  localparam logic signed [7:0] BIAS    = 8'(`FP16_BIAS);
  localparam logic signed [7:0] EXP_TOP = 8'((1 << EXP_BITS) - 1);

  typedef enum logic [1:0] {CORE_IDLE, CORE_UNPACK, CORE_ITER} core_state_e;

  core_state_e          state_q;
  logic [CW-1:0]        cnt_q;
  logic                 start;
  logic                 done;
  logic                 last_iter;
  // Latched request
  divsqrt_op_e          op_q;
  fp16_u                a_q, b_q;
  // Iteration state
  logic                 sign_q;
  logic signed [7:0]    exp_q;
  logic [RW-1:0]        rem_q;
  logic [QW-1:0]        q_q;
  logic [MW-1:0]        div_q;
  logic [SW-1:0]        rad_q;

  assign start = unit.start_div | unit.start_sqrt;

  // ----------------------------------------
  // Unpack and special cases
  // ----------------------------------------
  logic              a_zero, b_zero, a_spec, b_spec;
  logic              sign_ab;
  logic [MW-1:0]     ma, mb;
  logic              sqrt_odd;
  logic [MW:0]       rad_m;
  logic signed [7:0] div_exp, sqrt_exp;
  logic              special;
  fp16_u             spec_res;
  status_t           spec_status;

  // Zero exponent covers subnormals, flushed to zero
  assign a_zero  = (a_q.f.exponent == '0);
  assign b_zero  = (b_q.f.exponent == '0);
  // Infinity or NaN
  assign a_spec  = &a_q.f.exponent;
  assign b_spec  = &b_q.f.exponent;
  assign sign_ab = a_q.f.sign ^ b_q.f.sign;
  assign ma      = {1'b1, a_q.f.fraction};
  assign mb      = {1'b1, b_q.f.fraction};

  // Odd unbiased exponent gets one bit of pre-shift
  assign sqrt_odd = a_q.f.exponent[0] ^ BIAS[0];
  assign rad_m    = sqrt_odd ? {ma, 1'b0} : {1'b0, ma};
  assign div_exp  = $signed({3'b000, a_q.f.exponent}) - $signed({3'b000, b_q.f.exponent}) + BIAS;
  assign sqrt_exp = ($signed({3'b000, a_q.f.exponent}) + BIAS
                     - $signed({7'b0, sqrt_odd})) >>> 1;

  always_comb begin
    special      = 1'b1;
    spec_status  = '0;
    spec_res.raw = FP16_QNAN;
    if (op_q == SQRT) begin
      if (a_spec) begin
        spec_status.nv = 1'b1;
      end else if (a_zero) begin
        // Signed zero passes through, sqrt(-0) is -0
        spec_res.f = '{sign: a_q.f.sign, default: '0};
      end else if (a_q.f.sign) begin
        spec_status.nv = 1'b1;
      end else begin
        special = 1'b0;
      end
    end else begin
      if (a_spec || b_spec || (a_zero && b_zero)) begin
        spec_status.nv = 1'b1;
      end else if (b_zero) begin
        spec_res.f     = '{sign: sign_ab, exponent: '1, fraction: '0};
        spec_status.dz = 1'b1;
      end else if (a_zero) begin
        spec_res.f = '{sign: sign_ab, default: '0};
      end else begin
        special = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // Radix-2 restoring step
  // ----------------------------------------
  logic [RW-1:0] rem_sh, trial, diff;
  logic          q_bit;
  logic [QW-1:0] q_nx;

  always_comb begin
    if (op_q == SQRT) begin
      // Bring down two radicand bits, trial is 4q+1
      rem_sh = {rem_q[RW-3:0], rad_q[SW-1 -: 2]};
      trial  = {1'b0, q_q, 2'b01};
    end else begin
      rem_sh = rem_q;
      trial  = RW'(div_q);
    end
    q_bit = (rem_sh >= trial);
    diff  = q_bit ? (rem_sh - trial) : rem_sh;
    q_nx  = {q_q[QW-2:0], q_bit};
  end

  // ----------------------------------------
  // Normalize and pack, last iteration
  // ----------------------------------------
  logic                       lead;
  logic [`FP16_MANT_BITS-1:0] mant;
  logic                       inexact;
  logic signed [7:0]          exp_res;
  fp16_u                      norm_res;
  status_t                    norm_status;

  // Quotient below one needs one position of left shift
  assign lead    = q_nx[QW-1];
  assign mant    = lead ? q_nx[QW-2 -: `FP16_MANT_BITS] : q_nx[QW-3 -: `FP16_MANT_BITS];
  assign inexact = (lead ? |q_nx[QW-MW-1:0] : |q_nx[QW-MW-2:0]) | (diff != '0);
  assign exp_res = exp_q - $signed({7'b0, ~lead});

  always_comb begin
    norm_status    = '0;
    norm_status.nx = inexact;
    if (exp_res >= EXP_TOP) begin
      // Truncation saturates at the largest finite value
      norm_res.raw   = FP16_MAX_FINITE;
      norm_res.f.sign = sign_q;
      norm_status.of = 1'b1;
      norm_status.nx = 1'b1;
    end else if (exp_res <= 8'sd0) begin
      norm_res.f     = '{sign: sign_q, default: '0};
      norm_status.uf = 1'b1;
      norm_status.nx = 1'b1;
    end else begin
      norm_res.f = '{sign: sign_q, exponent: exp_res[EXP_BITS-1:0], fraction: mant};
    end
  end

  // ----------------------------------------
  // Sequencing
  // ----------------------------------------
  assign last_iter = (state_q == CORE_ITER) && (cnt_q == CW'(QW - 1));
  assign done      = ((state_q == CORE_UNPACK) && special) || last_iter;

  assign unit.unit_done  = done;
  // Finishing cycle already accepts the next start
  assign unit.unit_ready = (state_q == CORE_IDLE) || done;
  assign unit.result     = (state_q == CORE_UNPACK) ? spec_res : norm_res;
  assign unit.status     = (state_q == CORE_UNPACK) ? spec_status : norm_status;

  always_ff @(posedge clk_i) begin
    if (rst_i || unit.kill) begin
      state_q <= CORE_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        CORE_IDLE: begin
          if (start) begin
            state_q <= CORE_UNPACK;
          end
        end
        CORE_UNPACK: begin
          cnt_q <= '0;
          if (special) begin
            state_q <= start ? CORE_UNPACK : CORE_IDLE;
          end else begin
            state_q <= CORE_ITER;
          end
        end
        CORE_ITER: begin
          cnt_q <= cnt_q + 1'b1;
          if (last_iter) begin
            state_q <= start ? CORE_UNPACK : CORE_IDLE;
          end
        end
        default: state_q <= CORE_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk_i) begin
    if (start) begin
      op_q <= unit.start_sqrt ? SQRT : DIV;
      a_q  <= unit.operand_a;
      b_q  <= unit.operand_b;
    end
    if (state_q == CORE_UNPACK) begin
      sign_q <= (op_q == SQRT) ? 1'b0 : sign_ab;
      exp_q  <= (op_q == SQRT) ? sqrt_exp : div_exp;
      q_q    <= '0;
      div_q  <= mb;
      rem_q  <= (op_q == SQRT) ? '0 : RW'(ma);
      rad_q  <= {rad_m, {(SW-MW-1){1'b0}}};
    end else if (state_q == CORE_ITER) begin
      q_q   <= q_nx;
      // Division shifts the remainder after the subtract
      rem_q <= (op_q == SQRT) ? diff : {diff[RW-2:0], 1'b0};
      rad_q <= {rad_q[SW-3:0], 2'b00};
    end
  end

endmodule

// ==== divsqrt_top.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_top
  import fp16_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  // Request side
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  divsqrt_op_e            op_i,
  input  logic [`FP16_WIDTH-1:0] operand_a_i,
  // Ignored for SQRT
  input  logic [`FP16_WIDTH-1:0] operand_b_i,
  // Response side
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output logic [`FP16_WIDTH-1:0] result_o,
  output status_t                status_o,
  input  logic                   flush_i,
  output logic                   busy_o
);

  divsqrt_req_t in_req, head_req;
  logic         head_valid, head_ready;
  divsqrt_rsp_t rsp, out_rsp;
  logic         rsp_valid, rsp_ready;
  logic         in_busy, out_busy, ctrl_busy;

  divsqrt_if u_unit_if ();

  assign in_req = '{op: op_i, a: operand_a_i, b: operand_b_i};

  // ----------------------------------------
  // Input pipeline
  // ----------------------------------------
  pipe_stages #(
    .WIDTH ($bits(divsqrt_req_t)),
    .DEPTH (`DIVSQRT_IN_REGS)
  ) u_in_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .valid_i     (in_valid_i),
    .ready_o     (in_ready_o),
    .data_i      (in_req),
    .valid_o     (head_valid),
    .ready_i     (head_ready),
    .data_o      (head_req),
    .any_valid_o (in_busy)
  );

  divsqrt_ctrl u_ctrl (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .req_valid_i (head_valid),
    .req_ready_o (head_ready),
    .req_i       (head_req),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_o       (rsp),
    .busy_o      (ctrl_busy),
    .unit        (u_unit_if.ctrl)
  );

  fp16_divsqrt_iter u_core (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .unit  (u_unit_if.core)
  );

  // ----------------------------------------
  // Output pipeline
  // ----------------------------------------
  pipe_stages #(
    .WIDTH ($bits(divsqrt_rsp_t)),
    .DEPTH (`DIVSQRT_OUT_REGS)
  ) u_out_pipe (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .valid_i     (rsp_valid),
    .ready_o     (rsp_ready),
    .data_i      (rsp),
    .valid_o     (out_valid_o),
    .ready_i     (out_ready_i),
    .data_o      (out_rsp),
    .any_valid_o (out_busy)
  );

  assign result_o = out_rsp.result.raw;
  assign status_o = out_rsp.status;
  // Anything in flight anywhere
  assign busy_o   = in_busy | ctrl_busy | out_busy;

endmodule

// ==== divsqrt_properties.sv ====
`timescale 1ns/1ps
`include "divsqrt_settings.svh"

module divsqrt_properties
  import fp16_pkg::*;
  import divsqrt_op_pkg::*;
(
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   in_valid_i,
  input logic                   in_ready_o,
  input divsqrt_op_e            op_i,
  input logic [`FP16_WIDTH-1:0] operand_a_i,
  input logic [`FP16_WIDTH-1:0] operand_b_i,
  input logic                   out_valid_o,
  input logic                   out_ready_i,
  input logic [`FP16_WIDTH-1:0] result_o,
  input status_t                status_o,
  input logic                   flush_i,
  input logic                   busy_o
);

  // Number of failed assertions so far
  int violation_count = 0;

  // ----------------------------------------
  // Request side
  // ----------------------------------------
  // Pending request keeps valid and payload until taken
  a_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i && !in_ready_o && !flush_i |=>
      in_valid_i && $stable({op_i, operand_a_i, operand_b_i}))
    else begin
      violation_count++;
      $error("request dropped or changed before acceptance");
    end

  // ----------------------------------------
  // Response side
  // ----------------------------------------
  // Stalled result stays put
  a_rsp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o))
    else begin
      violation_count++;
      $error("result dropped or changed under back-pressure");
    end

  // Flush empties everything in one cycle
  a_flush_clears: assert property (@(posedge clk_i) disable iff (rst_i)
    flush_i |=> !out_valid_o && !busy_o)
    else begin
      violation_count++;
      $error("output valid or busy still high after flush");
    end

  // No result out of reset
  a_reset_quiet: assert property (@(posedge clk_i)
    rst_i |=> !out_valid_o)
    else begin
      violation_count++;
      $error("output valid high during reset");
    end

endmodule

bind divsqrt_top divsqrt_properties u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .op_i        (op_i),
  .operand_a_i (operand_a_i),
  .operand_b_i (operand_b_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .result_o    (result_o),
  .status_o    (status_o),
  .flush_i     (flush_i),
  .busy_o      (busy_o)
);

// ==== tb_divsqrt.sv ====
`timescale 1ns/1ps

module tb_divsqrt
  import fp16_pkg::*;
  import divsqrt_op_pkg::*;
();

  // Cycles any single wait may take
  localparam int unsigned TIMEOUT = 200;
  localparam logic [31:0] SEED    = 32'hc400f93a;

  // Status patterns with flags in the order nv dz of uf nx
  localparam status_t ST_OK    = 5'b00000;
  localparam status_t ST_NV    = 5'b10000;
  localparam status_t ST_DZ    = 5'b01000;
  localparam status_t ST_NX    = 5'b00001;
  localparam status_t ST_OF_NX = 5'b00101;
  localparam status_t ST_UF_NX = 5'b00011;

  logic        clk_i;
  logic        rst_i;
  logic        in_valid_i;
  logic        in_ready_o;
  divsqrt_op_e op_i;
  logic [15:0] operand_a_i;
  logic [15:0] operand_b_i;
  logic        out_valid_o;
  logic        out_ready_i;
  logic [15:0] result_o;
  status_t     status_o;
  logic        flush_i;
  logic        busy_o;

  // Separate random streams for input gaps and output stalls
  logic [31:0] gap_state;
  logic [31:0] stall_state;

  typedef struct {
    string       name;
    divsqrt_op_e op;
    fp16_u       a;
    fp16_u       b;
    fp16_u       res;
    status_t     st;
  } vector_t;

  vector_t vectors [$];

  divsqrt_top u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .flush_i     (flush_i),
    .busy_o      (busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_stop();
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_result(input string name, input fp16_u exp, input fp16_u act);
    if (act.raw !== exp.raw) begin
      $display("ERR %s: result expected %h, actual %h", name, exp.raw, act.raw);
      fail_stop();
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("ERR %s: status expected %b, actual %b", name, exp, act);
      fail_stop();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected %b, actual %b", name, exp, act);
      fail_stop();
    end
  endtask

  // Any failed assertion ends the run
  always @(posedge clk_i) begin
    if (u_dut.u_props.violation_count != 0) begin
      $display("an assertion on the DUT ports failed");
      fail_stop();
    end
  end

  function automatic void add_vector(input string name, input divsqrt_op_e op,
                                     input logic [15:0] a, input logic [15:0] b,
                                     input logic [15:0] res, input status_t st);
    vector_t v;
    v.name    = name;
    v.op      = op;
    v.a.raw   = a;
    v.b.raw   = b;
    v.res.raw = res;
    v.st      = st;
    vectors.push_back(v);
  endfunction

  // Expected values worked out by hand for RTZ rounding
  task automatic load_vectors();
    add_vector("div_6_2",           DIV,  16'h4600, 16'h4000, 16'h4200, ST_OK);
    add_vector("div_1_half",        DIV,  16'h3C00, 16'h3800, 16'h4000, ST_OK);
    add_vector("div_neg9_3",        DIV,  16'hC880, 16'h4200, 16'hC200, ST_OK);
    add_vector("div_1_3",           DIV,  16'h3C00, 16'h4200, 16'h3555, ST_NX);
    add_vector("div_overflow",      DIV,  16'h7800, 16'h0400, 16'h7BFF, ST_OF_NX);
    add_vector("div_underflow",     DIV,  16'h0400, 16'h7800, 16'h0000, ST_UF_NX);
    // Junk in b must be ignored for sqrt
    add_vector("sqrt_4",            SQRT, 16'h4400, 16'h1234, 16'h4000, ST_OK);
    add_vector("sqrt_2",            SQRT, 16'h4000, 16'hFFFF, 16'h3DA8, ST_NX);
    add_vector("sqrt_9",            SQRT, 16'h4880, 16'h0000, 16'h4200, ST_OK);
    add_vector("sqrt_neg0",         SQRT, 16'h8000, 16'h3C00, 16'h8000, ST_OK);
    add_vector("div_by_zero",       DIV,  16'h3C00, 16'h0000, 16'h7C00, ST_DZ);
    add_vector("div_neg_by_zero",   DIV,  16'hC000, 16'h0000, 16'hFC00, ST_DZ);
    add_vector("div_0_0",           DIV,  16'h0000, 16'h0000, 16'h7E00, ST_NV);
    add_vector("sqrt_neg1",         SQRT, 16'hBC00, 16'h0000, 16'h7E00, ST_NV);
    add_vector("div_inf",           DIV,  16'h7C00, 16'h3C00, 16'h7E00, ST_NV);
    // Subnormals count as zero
    add_vector("div_by_subnormal",  DIV,  16'h3C00, 16'h0001, 16'h7C00, ST_DZ);
    add_vector("div_subnormal_num", DIV,  16'h8200, 16'h3C00, 16'h8000, ST_OK);
    add_vector("sqrt_nan",          SQRT, 16'h7E00, 16'h0000, 16'h7E00, ST_NV);
  endtask

  // ----------------------------------------
  // Request and response transfers
  // ----------------------------------------
  // Entered on a falling edge and returns on the falling edge after the transfer
  task automatic push_request(input int idx);
    int unsigned waited;
    waited      = 0;
    in_valid_i  = 1'b1;
    op_i        = vectors[idx].op;
    operand_a_i = vectors[idx].a.raw;
    operand_b_i = vectors[idx].b.raw;
    #1;
    while (!in_ready_o) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: in_ready_o stayed low for %s", vectors[idx].name);
        fail_stop();
      end
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  // Random out_ready_i each cycle until one result is taken
  task automatic pull_response(output fp16_u res, output status_t st);
    int unsigned waited;
    logic        got;
    waited = 0;
    got    = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      stall_state = xorshift32(stall_state);
      out_ready_i = (stall_state[1:0] != 2'b00);
      #1;
      if (out_valid_o && out_ready_i) begin
        res.raw = result_o;
        st      = status_o;
        got     = 1'b1;
      end else begin
        waited++;
        if (waited > TIMEOUT) begin
          $display("timeout: no result arrived within %0d cycles", TIMEOUT);
          fail_stop();
        end
      end
    end
  endtask

  task automatic issue_all();
    int unsigned gap;
    @(negedge clk_i);
    for (int i = 0; i < vectors.size(); i++) begin
      gap_state = xorshift32(gap_state);
      gap       = (gap_state[2:0] > 3'd4) ? gap_state[4:3] : 0;
      repeat (gap) @(negedge clk_i);
      push_request(i);
    end
  endtask

  // Results must come back in issue order
  task automatic collect_all();
    fp16_u   res;
    status_t st;
    for (int i = 0; i < vectors.size(); i++) begin
      pull_response(res, st);
      check_result(vectors[i].name, vectors[i].res, res);
      check_status(vectors[i].name, vectors[i].st, st);
    end
  endtask

  // All expected results are in, so any further valid is a duplicate
  task automatic wait_idle();
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    #1;
    while (busy_o || out_valid_o) begin
      if (out_valid_o) begin
        $display("an extra result appeared after all expected results");
        fail_stop();
      end
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: busy_o stayed high after the last result");
        fail_stop();
      end
      @(negedge clk_i);
      #1;
    end
  endtask

  // ----------------------------------------
  // Flush with work in flight
  // ----------------------------------------
  task automatic run_flush_test();
    fp16_u       res;
    status_t     st;
    int unsigned quiet;
    int unsigned waited;
    waited = 0;
    @(negedge clk_i);
    out_ready_i = 1'b0;
    // One item each in the output pipe, the core and the input pipe
    push_request(0);
    push_request(1);
    push_request(2);
    #1;
    check_flag("flush_busy_before", 1'b1, busy_o);
    // First result parks in the stalled output pipe
    while (!out_valid_o) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("timeout: no result reached the output before the flush");
        fail_stop();
      end
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    #1;
    check_flag("flush_out_valid", 1'b0, out_valid_o);
    check_flag("flush_busy", 1'b0, busy_o);
    // Nothing of the flushed work may show up
    for (quiet = 0; quiet < 30; quiet++) begin
      @(negedge clk_i);
      #1;
      if (out_valid_o) begin
        $display("a flushed operation still produced a result");
        fail_stop();
      end
    end
    @(negedge clk_i);
    push_request(3);
    pull_response(res, st);
    check_result({vectors[3].name, "_after_flush"}, vectors[3].res, res);
    check_status({vectors[3].name, "_after_flush"}, vectors[3].st, st);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_i       = 1'b1;
    in_valid_i  = 1'b0;
    op_i        = DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    out_ready_i = 1'b0;
    flush_i     = 1'b0;
    gap_state   = SEED;
    stall_state = xorshift32(SEED);
    load_vectors();

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    check_flag("reset_in_ready", 1'b1, in_ready_o);
    check_flag("reset_out_valid", 1'b0, out_valid_o);
    check_flag("reset_busy", 1'b0, busy_o);

    // Table run with random gaps and stalls
    fork
      issue_all();
      collect_all();
    join
    wait_idle();

    run_flush_test();
    wait_idle();

    if (u_dut.u_props.violation_count != 0) begin
      $display("%0d assertion failures", u_dut.u_props.violation_count);
      fail_stop();
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

// ==== list.f ====
+incdir+.
fp16_pkg.sv
divsqrt_op_pkg.sv
divsqrt_if.sv
pipe_stages.sv
divsqrt_ctrl.sv
fp16_divsqrt_iter.sv
divsqrt_top.sv
divsqrt_properties.sv
tb_divsqrt.sv
